/* Bender.yml */
package:
  name: fetch_stage2

sources:
  - include_dirs:
      - source
    files:
      - source/fetchPkg.sv
      - source/preDecode.sv
      - source/redirectCtrl.sv
      - source/ctiQueue.sv
      - source/fetchStage2.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tbClock.sv
      - dv/fetchStage2Tb.sv

/* dv/fetchStage2Tb.sv */
// Testbench for the second fetch stage with a queue model and checking assertions
`timescale 1ns/1ps
`include "fetchStage_settings.svh"

module fetchStage2Tb;

  import fetchPkg::*;

  localparam int Depth         = `CTI_QUEUE_DEPTH;
  localparam int IW            = `SIZE_INSTRUCTION;
  localparam int RandomBundles = 60;
  // worst case a bundle plus a full drain of the queue
  localparam int TestCycles    = 16 + 60 + RandomBundles * 26;

  logic clk;
  logic arstN;
  logic fs1Ready;
  logic stall;
  logic recFlag;
  logic flagEx;
  logic commit;
  logic [`SIZE_PC-1:0] pcIn;
  logic [`SIZE_PC-1:0] ras;
  logic [`FETCH_WIDTH*IW-1:0] bundle;
  slotPredict_t [`FETCH_WIDTH-1:0] predict;
  ctiResolve_t resolve;
  instPacket_t [`FETCH_WIDTH-1:0] packet;
  logic [`FETCH_WIDTH-1:0] valid;
  redirect_t redirect;
  predUpdate_t update;
  logic fs2Ready;
  logic full;

  // queue model
  integer seed;
  int mHead;
  int mTail;
  int mCount;
  logic [`SIZE_PC-1:0] mPc [Depth];
  logic [`SIZE_PC-1:0] mTarget [Depth];
  ctrlType_e mType [Depth];
  logic mDir [Depth];
  logic expEn;
  predUpdate_t expUpd;

  tbClock #(.PeriodNs(100), .ResetCycles(16)) i_tbClock (.clk_o(clk), .arstN_o(arstN));

  fetchStage2 i_dut (
    .clk                 (clk),
    .arstN_i             (arstN),
    .fs1Ready_i          (fs1Ready),
    .stall_i             (stall),
    .recoverFlag_i       (recFlag),
    .pc_i                (pcIn),
    .instructionBundle_i (bundle),
    .addrRas_i           (ras),
    .predict_i           (predict),
    .resolve_i           (resolve),
    .flagRecoverEx_i     (flagEx),
    .commitCti_i         (commit),
    .packet_o            (packet),
    .valid_o             (valid),
    .redirect_o          (redirect),
    .update_o            (update),
    .fs2Ready_o          (fs2Ready),
    .ctiQueueFull_o      (full)
  );

  task automatic checkValue(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("error at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // kind 0 is plain, then return, call, jump, branch
  task automatic setSlot(input int k, input int kind, input logic pr, input logic hit);
    logic [7:0]    op;
    logic [IW-1:0] word;
    word = {$random(seed), $random(seed)};
    case (kind)
      1: op = OP_RETURN;
      2: op = OP_CALL;
      3: op = OP_JUMP;
      4: op = OP_BRANCH;
      default: op = {2'b01, word[61:56]};
    endcase
    word[IW-1 -: 8] = op;
    bundle[k*IW +: IW] = word;
    predict[k].btbHit     = hit;
    predict[k].prediction = pr;
    predict[k].btbTarget  = $random(seed);
  endtask

  task automatic quiet();
    fs1Ready = 1'b1;
    stall    = 1'b0;
    recFlag  = 1'b0;
    flagEx   = 1'b0;
    commit   = 1'b0;
    resolve  = '0;
    pcIn     = $random(seed) & ~32'h7;
    ras      = $random(seed);
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      setSlot(k, 0, 1'b0, 1'b1);
    end
  endtask

  // inputs are already set for this cycle, outputs checked before the edge
  task automatic evalCycle();
    logic [7:0]          op;
    logic [15:0]         off;
    logic [`SIZE_PC-1:0] slotPc [`FETCH_WIDTH];
    logic [`SIZE_PC-1:0] target [`FETCH_WIDTH];
    ctrlType_e           kind [`FETCH_WIDTH];
    logic                ctrl [`FETCH_WIDTH];
    logic                isFull;
    logic                miss;
    logic                accept;
    logic                enq;
    int                  first;
    int                  tag;
    #10;
    isFull = mCount > Depth - `FETCH_WIDTH;
    accept = fs1Ready & ~stall & ~isFull & ~recFlag & ~(resolve.valid & flagEx);
    first  = -1;
    for (int k = `FETCH_WIDTH - 1; k >= 0; k--) begin
      op        = bundle[k*IW + IW - 8 +: 8];
      off       = bundle[k*IW +: 16];
      slotPc[k] = pcIn + k * `PC_STEP;
      ctrl[k]   = 1'b1;
      case (op)
        OP_RETURN: kind[k] = ctrlReturn;
        OP_CALL:   kind[k] = ctrlCall;
        OP_JUMP:   kind[k] = ctrlJump;
        OP_BRANCH: kind[k] = ctrlBranch;
        default: begin
          kind[k] = ctrlJump;
          ctrl[k] = 1'b0;
        end
      endcase
      // offset counts words from the next slot
      target[k] = slotPc[k] + `PC_STEP + 32'($signed(off)) * 8;
      if (kind[k] == ctrlReturn) begin
        target[k] = predict[k].btbTarget;
      end
      if (ctrl[k] && (predict[k].prediction || kind[k] != ctrlBranch)) begin
        first = k;
      end
    end
    miss = (first >= 0) && !predict[first].btbHit;
    tag  = mTail;
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      enq = (first < 0 || k < first) ?
            (ctrl[k] && kind[k] == ctrlBranch && !predict[k].prediction) : (k == first);
      checkValue($sformatf("valid_o[%0d]", k), first < 0 || k <= first, valid[k]);
      checkValue($sformatf("packet_o[%0d].pc", k), slotPc[k], packet[k].pc);
      checkValue($sformatf("packet_o[%0d].instruction", k), bundle[k*IW +: IW],
                 packet[k].instruction);
      checkValue($sformatf("packet_o[%0d].target", k),
                 (k == first && miss && kind[k] == ctrlReturn) ? ras : target[k],
                 packet[k].target);
      checkValue($sformatf("packet_o[%0d].ctiqTag", k), tag % Depth, packet[k].ctiqTag);
      checkValue($sformatf("packet_o[%0d].prediction", k), predict[k].prediction,
                 packet[k].prediction);
      if (enq) begin
        if (accept) begin
          mPc[tag % Depth]   = slotPc[k];
          mType[tag % Depth] = kind[k];
        end
        tag++;
      end
    end
    checkValue("redirect_o.recover", miss && !stall && !isFull, redirect.recover);
    checkValue("redirect_o.isReturn", miss && kind[first] == ctrlReturn, redirect.isReturn);
    checkValue("redirect_o.isCall", miss && kind[first] == ctrlCall, redirect.isCall);
    if (first >= 0) begin
      checkValue("redirect_o.target", target[first], redirect.target);
      checkValue("redirect_o.callPc", slotPc[first], redirect.callPc);
    end
    checkValue("ctiQueueFull_o", isFull, full);
    checkValue("fs2Ready_o", fs1Ready && !isFull, fs2Ready);
    checkValue("update_o.en", expEn, update.en);
    if (expEn) begin
      checkValue("update_o.pc", expUpd.pc, update.pc);
      checkValue("update_o.target", expUpd.target, update.target);
      checkValue("update_o.ctrlType", expUpd.ctrlType, update.ctrlType);
      checkValue("update_o.dir", expUpd.dir, update.dir);
    end
    // state after the coming rising edge
    expEn = commit && mCount > 0;
    if (expEn) begin
      expUpd.pc       = mPc[mHead];
      expUpd.target   = mTarget[mHead];
      expUpd.ctrlType = mType[mHead];
      expUpd.dir      = mDir[mHead];
      mHead           = (mHead + 1) % Depth;
      mCount--;
    end
    if (resolve.valid) begin
      mTarget[resolve.tag] = resolve.target;
      mDir[resolve.tag]    = resolve.taken;
    end
    if (recFlag) begin
      mTail  = mHead;
      mCount = 0;
    end else if (resolve.valid && flagEx) begin
      mTail  = (resolve.tag + 1) % Depth;
      mCount = (mTail - mHead + Depth) % Depth;
    end else if (accept) begin
      mCount += tag - mTail;
      mTail   = tag % Depth;
    end
  endtask

  // resolve every live entry, then commit them all in fetch order
  task automatic drainQueue();
    int n;
    n = mCount;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      quiet();
      fs1Ready       = 1'b0;
      resolve.valid  = 1'b1;
      resolve.tag    = 4'((mHead + i) % Depth);
      resolve.target = $random(seed);
      resolve.taken  = $random(seed);
      evalCycle();
    end
    repeat (n + 1) begin
      @(negedge clk);
      quiet();
      fs1Ready = 1'b0;
      commit   = 1'b1;
      evalCycle();
    end
  endtask

  initial begin
    #(TestCycles * 100 + 2000);
    $display("timeout: the test sequence did not finish in time");
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int kind;
    seed   = 84;
    mHead  = 0;
    mTail  = 0;
    mCount = 0;
    expEn  = 1'b0;
    expUpd = '0;
    quiet();
    wait (arstN);
    // reset state with a plain bundle
    @(negedge clk);
    quiet();
    evalCycle();
    // return miss in slot 1
    @(negedge clk);
    quiet();
    setSlot(1, 1, 1'b1, 1'b0);
    evalCycle();
    // not-taken branch ahead of a call miss
    @(negedge clk);
    quiet();
    setSlot(0, 4, 1'b0, 1'b1);
    setSlot(2, 2, 1'b1, 1'b0);
    evalCycle();
    drainQueue();
    repeat (RandomBundles) begin
      @(negedge clk);
      quiet();
      for (int k = 0; k < `FETCH_WIDTH; k++) begin
        kind = $unsigned($random(seed)) % 8;
        setSlot(k, (kind > 4) ? 0 : kind, $random(seed), $random(seed));
      end
      stall    = ($random(seed) & 3) == 0;
      fs1Ready = ($random(seed) & 7) != 0;
      evalCycle();
      if (mCount > 8) begin
        drainQueue();
      end
    end
    drainQueue();
    // fill with not-taken branches until the queue backs up
    repeat (5) begin
      @(negedge clk);
      quiet();
      for (int k = 0; k < `FETCH_WIDTH; k++) begin
        setSlot(k, 4, 1'b0, 1'b1);
      end
      evalCycle();
    end
    // jump miss while full raises no recover
    @(negedge clk);
    quiet();
    setSlot(0, 3, 1'b1, 1'b0);
    evalCycle();
    @(negedge clk);
    quiet();
    recFlag = 1'b1;
    evalCycle();
    @(negedge clk);
    quiet();
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      setSlot(k, 4, 1'b0, 1'b1);
    end
    evalCycle();
    // execute recovery on the second entry cuts the tail behind it
    @(negedge clk);
    quiet();
    fs1Ready       = 1'b0;
    flagEx         = 1'b1;
    resolve.valid  = 1'b1;
    resolve.tag    = 4'((mHead + 1) % Depth);
    resolve.target = $random(seed);
    resolve.taken  = 1'b1;
    evalCycle();
    @(negedge clk);
    quiet();
    evalCycle();
    drainQueue();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* dv/tbClock.sv */
// Testbench clock and reset source with a fixed reset length
`timescale 1ns/1ps

module tbClock #(
  parameter int PeriodNs    = 100,
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic arstN_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release lands on a falling edge, away from the sampling edge
  initial begin
    arstN_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    arstN_o = 1'b1;
  end

endmodule

/* files.f */
+incdir+source
source/fetchPkg.sv
source/preDecode.sv
source/redirectCtrl.sv
source/ctiQueue.sv
source/fetchStage2.sv
dv/tbClock.sv
dv/fetchStage2Tb.sv

/* source/ctiQueue.sv */
// Circular control-transfer queue that issues tags, records resolutions and feeds updates
`timescale 1ns/1ps
`include "fetchStage_settings.svh"

module ctiQueue (
  input  logic                                       clk,
  input  logic                                       arstN_i,
  input  logic                                       write_i,
  input  logic [`FETCH_WIDTH-1:0]                    enqVector_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]      slotPc_i,
  input  fetchPkg::ctrlType_e [`FETCH_WIDTH-1:0]     slotType_i,
  input  logic                                       recoverFlag_i,
  input  fetchPkg::ctiResolve_t                      resolve_i,
  input  logic                                       flagRecoverEx_i,
  input  logic                                       commitCti_i,
  output logic [`FETCH_WIDTH-1:0][`SIZE_CTI_LOG-1:0] slotTag_o,
  output fetchPkg::predUpdate_t                      update_o,
  output logic                                       full_o
);

  import fetchPkg::*;

  localparam int Depth = `CTI_QUEUE_DEPTH;
  localparam logic [`SIZE_CTI_LOG:0] DepthCount = `CTI_QUEUE_DEPTH;
  localparam logic [`SIZE_CTI_LOG:0] FullLevel  = `CTI_QUEUE_DEPTH - `FETCH_WIDTH;

  logic [`SIZE_CTI_LOG-1:0] head;
  logic [`SIZE_CTI_LOG-1:0] tail;
  logic [`SIZE_CTI_LOG:0]   count;
  logic [`SIZE_CTI_LOG-1:0] headNext;
  logic [`SIZE_CTI_LOG:0]   countKeep;
  logic [`SIZE_CTI_LOG:0]   enqCount;
  logic [`SIZE_CTI_LOG-1:0] truncTail;
  logic [`SIZE_CTI_LOG-1:0] truncDiff;
  logic [`SIZE_CTI_LOG:0]   truncCount;
  logic                     doWrite;
  logic                     doCommit;
  logic                     truncate;
  logic                     writeEn;

  logic [`SIZE_PC-1:0] pcQ       [Depth];
  ctrlType_e           typeQ     [Depth];
  logic [`SIZE_PC-1:0] targetQ   [Depth];
  logic                dirQ      [Depth];
  logic                resolvedQ [Depth];

  // fewer than a bundle of free entries counts as full
  assign full_o   = count > FullLevel;
  assign doWrite  = write_i & ~full_o;
  assign doCommit = commitCti_i & (count != '0);
  assign truncate = resolve_i.valid & flagRecoverEx_i;
  assign writeEn  = doWrite & ~recoverFlag_i & ~truncate;

  assign headNext  = head + doCommit;
  assign countKeep = count - doCommit;
  assign truncTail = resolve_i.tag + 1'b1;
  assign truncDiff = truncTail - headNext;
  // zero distance with live entries means the queue wraps completely
  assign truncCount = (truncDiff != '0) ? {1'b0, truncDiff} :
                      (countKeep == '0) ? '0 : DepthCount;

  // enqueued slots take consecutive tags from the tail
  always_comb begin
    enqCount = '0;
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      slotTag_o[k] = tail + enqCount[`SIZE_CTI_LOG-1:0];
      enqCount     = enqCount + enqVector_i[k];
    end
    if (!doWrite) begin
      enqCount = '0;
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head <= headNext;
      if (recoverFlag_i) begin
        tail  <= headNext;
        count <= '0;
      end else if (truncate) begin
        tail  <= truncTail;
        count <= truncCount;
      end else begin
        tail  <= tail + enqCount[`SIZE_CTI_LOG-1:0];
        count <= countKeep + enqCount;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      if (writeEn && enqVector_i[k]) begin
        pcQ[slotTag_o[k]]       <= slotPc_i[k];
        typeQ[slotTag_o[k]]     <= slotType_i[k];
        resolvedQ[slotTag_o[k]] <= 1'b0;
      end
    end
    if (resolve_i.valid) begin
      targetQ[resolve_i.tag]   <= resolve_i.target;
      dirQ[resolve_i.tag]      <= resolve_i.taken;
      resolvedQ[resolve_i.tag] <= 1'b1;
    end
  end

  // update write trails the commit pulse by one clock
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      update_o.en <= 1'b0;
    end else begin
      update_o.en <= doCommit;
      if (doCommit) begin
        update_o.pc       <= pcQ[head];
        update_o.target   <= targetQ[head];
        update_o.ctrlType <= typeQ[head];
        update_o.dir      <= dirQ[head] & resolvedQ[head];
      end
    end
  end

endmodule

/* source/fetchPkg.sv */
// Control types, opcode values and slot structs for the second fetch stage
`include "fetchStage_settings.svh"

package fetchPkg;

  // encoding follows the predictor update bus
  typedef enum logic [1:0] {
    ctrlReturn = 2'b00,
    ctrlCall   = 2'b01,
    ctrlJump   = 2'b10,
    ctrlBranch = 2'b11
  } ctrlType_e;

  // opcode byte sits in the top of the instruction
  localparam logic [7:0] OP_RETURN = 8'h10;
  localparam logic [7:0] OP_CALL   = 8'h11;
  localparam logic [7:0] OP_JUMP   = 8'h12;
  localparam logic [7:0] OP_BRANCH = 8'h13;

  typedef struct packed {
    logic                btbHit;
    logic                prediction;
    logic [`SIZE_PC-1:0] btbTarget;
  } slotPredict_t;

  typedef struct packed {
    logic                isCtrl;
    ctrlType_e           ctrlType;
    logic [`SIZE_PC-1:0] target;
  } slotDecode_t;

  typedef struct packed {
    logic [`SIZE_INSTRUCTION-1:0] instruction;
    logic [`SIZE_PC-1:0]          pc;
    logic [`SIZE_PC-1:0]          target;
    logic [`SIZE_CTI_LOG-1:0]     ctiqTag;
    logic                         prediction;
  } instPacket_t;

  typedef struct packed {
    logic                     valid;
    logic [`SIZE_CTI_LOG-1:0] tag;
    logic [`SIZE_PC-1:0]      target;
    logic                     taken;
  } ctiResolve_t;

  typedef struct packed {
    logic                en;
    logic [`SIZE_PC-1:0] pc;
    logic [`SIZE_PC-1:0] target;
    ctrlType_e           ctrlType;
    logic                dir;
  } predUpdate_t;

  typedef struct packed {
    logic                recover;
    logic                isReturn;
    logic                isCall;
    logic [`SIZE_PC-1:0] target;
    logic [`SIZE_PC-1:0] callPc;
  } redirect_t;

endpackage

/* source/fetchStage2.sv */
// Second fetch stage top: slot split, predecode, redirect control and CTI queue
`timescale 1ns/1ps
`include "fetchStage_settings.svh"

module fetchStage2 (
  input  logic                                          clk,
  input  logic                                          arstN_i,
  input  logic                                          fs1Ready_i,
  input  logic                                          stall_i,
  input  logic                                          recoverFlag_i,
  input  logic [`SIZE_PC-1:0]                           pc_i,
  input  logic [`FETCH_WIDTH*`SIZE_INSTRUCTION-1:0]     instructionBundle_i,
  input  logic [`SIZE_PC-1:0]                           addrRas_i,
  input  fetchPkg::slotPredict_t [`FETCH_WIDTH-1:0]     predict_i,
  input  fetchPkg::ctiResolve_t                         resolve_i,
  input  logic                                          flagRecoverEx_i,
  input  logic                                          commitCti_i,
  output fetchPkg::instPacket_t [`FETCH_WIDTH-1:0]      packet_o,
  output logic [`FETCH_WIDTH-1:0]                       valid_o,
  output fetchPkg::redirect_t                           redirect_o,
  output fetchPkg::predUpdate_t                         update_o,
  output logic                                          fs2Ready_o,
  output logic                                          ctiQueueFull_o
);

  import fetchPkg::*;

  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]          slotPc;
  logic [`FETCH_WIDTH-1:0][`SIZE_INSTRUCTION-1:0] slotInst;
  slotDecode_t [`FETCH_WIDTH-1:0]                 decode;
  ctrlType_e [`FETCH_WIDTH-1:0]                   slotType;
  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]          slotTarget;
  logic [`FETCH_WIDTH-1:0][`SIZE_CTI_LOG-1:0]     slotTag;
  logic [`FETCH_WIDTH-1:0]                        enqVector;
  logic                                           queueFull;

  // slot 0 occupies the low bits of the bundle
  assign slotInst = instructionBundle_i;

  for (genvar k = 0; k < `FETCH_WIDTH; k++) begin : gSlot
    assign slotPc[k] = pc_i + `SIZE_PC'(k * `PC_STEP);

    preDecode i_preDecode (
      .pc_i          (slotPc[k]),
      .instruction_i (slotInst[k]),
      .btbTarget_i   (predict_i[k].btbTarget),
      .decode_o      (decode[k])
    );

    assign slotType[k] = decode[k].ctrlType;
    assign packet_o[k] = '{instruction: slotInst[k], pc: slotPc[k], target: slotTarget[k],
                           ctiqTag: slotTag[k], prediction: predict_i[k].prediction};
  end

  redirectCtrl i_redirectCtrl (
    .slotPc_i     (slotPc),
    .decode_i     (decode),
    .predict_i    (predict_i),
    .addrRas_i    (addrRas_i),
    .stall_i      (stall_i),
    .queueFull_i  (queueFull),
    .validMask_o  (valid_o),
    .enqVector_o  (enqVector),
    .slotTarget_o (slotTarget),
    .redirect_o   (redirect_o)
  );

  ctiQueue i_ctiQueue (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .write_i         (fs1Ready_i & ~stall_i),
    .enqVector_i     (enqVector),
    .slotPc_i        (slotPc),
    .slotType_i      (slotType),
    .recoverFlag_i   (recoverFlag_i),
    .resolve_i       (resolve_i),
    .flagRecoverEx_i (flagRecoverEx_i),
    .commitCti_i     (commitCti_i),
    .slotTag_o       (slotTag),
    .update_o        (update_o),
    .full_o          (queueFull)
  );

  assign ctiQueueFull_o = queueFull;
  assign fs2Ready_o     = fs1Ready_i & ~queueFull;

endmodule

/* source/fetchStage_settings.svh */
// Widths and depths shared by the second fetch stage of the front end
`ifndef FETCHSTAGE_SETTINGS_SVH
`define FETCHSTAGE_SETTINGS_SVH

// bundle geometry
`define FETCH_WIDTH 4
`define SIZE_PC 32
`define SIZE_INSTRUCTION 64

// byte distance between neighbouring slots
`define PC_STEP 8

// control-transfer queue
`define CTI_QUEUE_DEPTH 16
`define SIZE_CTI_LOG 4

`endif

/* source/preDecode.sv */
// Single-slot predecoder that classifies a control instruction and forms its target
`timescale 1ns/1ps
`include "fetchStage_settings.svh"

module preDecode (
  input  logic [`SIZE_PC-1:0]          pc_i,
  input  logic [`SIZE_INSTRUCTION-1:0] instruction_i,
  input  logic [`SIZE_PC-1:0]          btbTarget_i,
  output fetchPkg::slotDecode_t        decode_o
);

  import fetchPkg::*;

  logic [7:0]          opcode;
  logic [15:0]         offset;
  logic [`SIZE_PC-1:0] directTarget;

  assign opcode = instruction_i[`SIZE_INSTRUCTION-1 -: 8];
  assign offset = instruction_i[15:0];

  // word offset scaled to bytes, relative to the following slot
  assign directTarget = pc_i + `SIZE_PC'(`PC_STEP)
                      + {{(`SIZE_PC-19){offset[15]}}, offset, 3'b000};

  always_comb begin
    decode_o.isCtrl   = 1'b1;
    decode_o.ctrlType = ctrlJump;
    decode_o.target   = directTarget;
    case (opcode)
      OP_RETURN: begin
        decode_o.ctrlType = ctrlReturn;
        // return target only known from the btb
        decode_o.target   = btbTarget_i;
      end
      OP_CALL: begin
        decode_o.ctrlType = ctrlCall;
      end
      OP_JUMP: begin
        decode_o.ctrlType = ctrlJump;
      end
      OP_BRANCH: begin
        decode_o.ctrlType = ctrlBranch;
      end
      default: begin
        decode_o.isCtrl = 1'b0;
      end
    endcase
  end

endmodule

/* source/redirectCtrl.sv */
// Picks the first taken control slot, trims the bundle and raises fetch redirects
`timescale 1ns/1ps
`include "fetchStage_settings.svh"

module redirectCtrl (
  input  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]  slotPc_i,
  input  fetchPkg::slotDecode_t [`FETCH_WIDTH-1:0] decode_i,
  input  fetchPkg::slotPredict_t [`FETCH_WIDTH-1:0] predict_i,
  input  logic [`SIZE_PC-1:0]                    addrRas_i,
  input  logic                                   stall_i,
  input  logic                                   queueFull_i,
  output logic [`FETCH_WIDTH-1:0]                validMask_o,
  output logic [`FETCH_WIDTH-1:0]                enqVector_o,
  output logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0]  slotTarget_o,
  output fetchPkg::redirect_t                    redirect_o
);

  import fetchPkg::*;

  localparam int IdxW = $clog2(`FETCH_WIDTH);

  logic [`FETCH_WIDTH-1:0] kept;
  logic [`FETCH_WIDTH-1:0] branchNT;
  logic                    firstFound;
  logic [IdxW-1:0]         firstIdx;
  slotDecode_t             firstDec;
  logic                    btbMiss;

  // taken or unconditional control ends the bundle
  always_comb begin
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      kept[k]     = decode_i[k].isCtrl
                  & (predict_i[k].prediction | (decode_i[k].ctrlType != ctrlBranch));
      branchNT[k] = decode_i[k].isCtrl & (decode_i[k].ctrlType == ctrlBranch)
                  & ~predict_i[k].prediction;
    end
  end

  // lowest kept slot wins
  always_comb begin
    firstFound = 1'b0;
    firstIdx   = '0;
    for (int k = `FETCH_WIDTH - 1; k >= 0; k--) begin
      if (kept[k]) begin
        firstFound = 1'b1;
        firstIdx   = IdxW'(k);
      end
    end
  end

  assign firstDec = decode_i[firstIdx];
  assign btbMiss  = firstFound & ~predict_i[firstIdx].btbHit;

  always_comb begin
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      validMask_o[k]  = ~firstFound | (k <= int'(firstIdx));
      slotTarget_o[k] = decode_i[k].target;
      if (!firstFound || k < int'(firstIdx)) begin
        enqVector_o[k] = branchNT[k];
      end else begin
        enqVector_o[k] = (k == int'(firstIdx));
      end
    end
    // ras supplies the return address on a btb miss
    if (btbMiss && firstDec.ctrlType == ctrlReturn) begin
      slotTarget_o[firstIdx] = addrRas_i;
    end
  end

  assign redirect_o.recover  = btbMiss & ~stall_i & ~queueFull_i;
  assign redirect_o.isReturn = btbMiss & (firstDec.ctrlType == ctrlReturn);
  assign redirect_o.isCall   = btbMiss & (firstDec.ctrlType == ctrlCall);
  assign redirect_o.target   = firstDec.target;
  assign redirect_o.callPc   = slotPc_i[firstIdx];

endmodule
